/* design/axi_pkg.sv */
package axi_pkg;

   localparam int AXI_ADDR_W = 64;
   localparam int AXI_DATA_W = 64;
   localparam int AXI_ID_W   = 4;
   localparam int AXI_STRB_W = AXI_DATA_W / 8;

   localparam logic [AXI_ID_W-1:0] AXI_ID_COPY    = 4'h1;
   localparam logic [1:0]          AXI_RESP_OKAY  = 2'b00;
   localparam logic [1:0]          AXI_BURST_INCR = 2'b01;
   localparam logic [2:0]          AXI_SIZE_WORD  = 3'd3; // 8 bytes per beat

   // shared by AW and AR
   typedef struct packed {
      logic [AXI_ADDR_W-1:0] addr;
      logic [AXI_ID_W-1:0]   id;
      logic [7:0]            len;
      logic [2:0]            size;
      logic [1:0]            burst;
      logic [2:0]            prot;
      logic [3:0]            cache;
      logic                  lock;
      logic [3:0]            qos;
   } axi_ax_t;

   typedef struct packed {
      logic [AXI_DATA_W-1:0] data;
      logic [AXI_STRB_W-1:0] strb;
      logic                  last;
   } axi_w_t;

   typedef struct packed {
      logic [AXI_DATA_W-1:0] data;
      logic [1:0]            resp;
      logic [AXI_ID_W-1:0]   id;
      logic                  last;
   } axi_r_t;

   typedef struct packed {
      logic [1:0]          resp;
      logic [AXI_ID_W-1:0] id;
   } axi_b_t;

   // single beat, full width, incrementing
   function automatic axi_ax_t axi_ax_single(input logic [AXI_ADDR_W-1:0] addr);
      axi_ax_t ax;
      ax       = '0;
      ax.addr  = addr;
      ax.id    = AXI_ID_COPY;
      ax.size  = AXI_SIZE_WORD;
      ax.burst = AXI_BURST_INCR;
      return ax;
   endfunction

endpackage

/* design/copy_pkg.sv */
package copy_pkg;

   import axi_pkg::*;

   localparam int CNT_W = 16;

   typedef struct packed {
      logic [AXI_ADDR_W-1:0] src;
      logic [AXI_ADDR_W-1:0] dst;
      logic [CNT_W-1:0]      cnt; // words of 8 bytes
   } copy_job_t;

   typedef struct packed {
      logic busy;
      logic done;
      logic err;
   } copy_stat_t;

   typedef enum logic [1:0] {
      IDLE,
      READ,
      WRITE,
      NEXT
   } copy_state_t;

endpackage

/* design/axi_rd_chan.sv */
`timescale 1ns/1ps

module axi_rd_chan
   import axi_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n_i,
   input  logic                  rd_req_i,
   input  logic [AXI_ADDR_W-1:0] rd_addr_i,
   input  logic                  ar_ready_i,
   input  logic                  r_valid_i,
   input  axi_r_t                r_i,
   output logic                  ar_valid_o,
   output axi_ax_t               ar_o,
   output logic                  r_ready_o,
   output logic                  rd_done_o,
   output logic [AXI_DATA_W-1:0] rd_data_o,
   output logic [1:0]            rd_resp_o
);

   logic                  ar_pend_q;
   logic                  r_pend_q;
   logic                  done_q;
   axi_ax_t               ar_q;
   logic [AXI_DATA_W-1:0] data_q;
   logic [1:0]            resp_q;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ar_pend_q <= 1'b0;
         r_pend_q  <= 1'b0;
         done_q    <= 1'b0;
      end else begin
         done_q <= 1'b0;
         if (rd_req_i) begin
            ar_pend_q <= 1'b1;
         end else if (ar_pend_q && ar_ready_i) begin
            ar_pend_q <= 1'b0;
            r_pend_q  <= 1'b1; // wait for the beat
         end
         if (r_pend_q && r_valid_i) begin
            r_pend_q <= 1'b0;
            done_q   <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rd_req_i)
         ar_q <= axi_ax_single(rd_addr_i);
      if (r_pend_q && r_valid_i) begin
         data_q <= r_i.data;
         resp_q <= r_i.resp;
      end
   end

   assign ar_valid_o = ar_pend_q;
   assign ar_o       = ar_q;
   assign r_ready_o  = r_pend_q;
   assign rd_done_o  = done_q;
   assign rd_data_o  = data_q;
   assign rd_resp_o  = resp_q;

endmodule

/* design/axi_wr_chan.sv */
`timescale 1ns/1ps

module axi_wr_chan
   import axi_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n_i,
   input  logic                  wr_req_i,
   input  logic [AXI_ADDR_W-1:0] wr_addr_i,
   input  logic [AXI_DATA_W-1:0] wr_data_i,
   input  logic                  aw_ready_i,
   input  logic                  w_ready_i,
   input  logic                  b_valid_i,
   input  axi_b_t                b_i,
   output logic                  aw_valid_o,
   output axi_ax_t               aw_o,
   output logic                  w_valid_o,
   output axi_w_t                w_o,
   output logic                  b_ready_o,
   output logic                  wr_done_o,
   output logic [1:0]            wr_resp_o
);

   logic                  aw_pend_q;
   logic                  w_pend_q;
   logic                  act_q;    // write in flight until B
   logic                  done_q;
   logic                  b_ready;
   axi_ax_t               aw_q;
   logic [AXI_DATA_W-1:0] data_q;
   logic [1:0]            resp_q;

   // both AW and W gone, response may come
   assign b_ready = act_q && !aw_pend_q && !w_pend_q;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         aw_pend_q <= 1'b0;
         w_pend_q  <= 1'b0;
         act_q     <= 1'b0;
         done_q    <= 1'b0;
      end else begin
         done_q <= 1'b0;
         if (wr_req_i) begin
            aw_pend_q <= 1'b1;
            w_pend_q  <= 1'b1;
            act_q     <= 1'b1;
         end else begin
            if (aw_pend_q && aw_ready_i)
               aw_pend_q <= 1'b0;
            if (w_pend_q && w_ready_i)
               w_pend_q <= 1'b0;
            if (b_ready && b_valid_i) begin
               act_q  <= 1'b0;
               done_q <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (wr_req_i) begin
         aw_q   <= axi_ax_single(wr_addr_i);
         data_q <= wr_data_i;
      end
      if (b_ready && b_valid_i)
         resp_q <= b_i.resp;
   end

   assign aw_valid_o = aw_pend_q;
   assign aw_o       = aw_q;
   assign w_valid_o  = w_pend_q;
   assign w_o        = '{data: data_q, strb: '1, last: 1'b1};
   assign b_ready_o  = b_ready;
   assign wr_done_o  = done_q;
   assign wr_resp_o  = resp_q;

endmodule

/* design/copy_ctrl.sv */
`timescale 1ns/1ps

module copy_ctrl
   import axi_pkg::*, copy_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n_i,
   input  logic                  start_i,
   input  copy_job_t             job_i,
   input  logic                  rd_done_i,
   input  logic [AXI_DATA_W-1:0] rd_data_i,
   input  logic [1:0]            rd_resp_i,
   input  logic                  wr_done_i,
   input  logic [1:0]            wr_resp_i,
   output copy_stat_t            stat_o,
   output logic                  rd_req_o,
   output logic [AXI_ADDR_W-1:0] rd_addr_o,
   output logic                  wr_req_o,
   output logic [AXI_ADDR_W-1:0] wr_addr_o,
   output logic [AXI_DATA_W-1:0] wr_data_o
);

   copy_state_t           state_q;
   logic                  rd_req_q;
   logic                  wr_req_q;
   logic                  done_q;
   logic                  err_q;
   logic                  accept;
   logic                  step;
   logic [AXI_ADDR_W-1:0] src_q;
   logic [AXI_ADDR_W-1:0] dst_q;
   logic [CNT_W-1:0]      cnt_q;
   logic [AXI_DATA_W-1:0] data_q;

   assign accept = start_i && (state_q == IDLE); // start while busy is dropped
   assign step   = wr_done_i && (state_q == WRITE);

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q  <= IDLE;
         rd_req_q <= 1'b0;
         wr_req_q <= 1'b0;
         done_q   <= 1'b0;
         err_q    <= 1'b0;
      end else begin
         rd_req_q <= 1'b0;
         wr_req_q <= 1'b0;
         done_q   <= 1'b0;
         case (state_q)
            IDLE: begin
               if (accept) begin
                  err_q <= 1'b0;
                  if (job_i.cnt != '0) begin
                     rd_req_q <= 1'b1;
                     state_q  <= READ;
                  end else begin
                     state_q <= NEXT;
                  end
               end
            end
            READ: begin
               if (rd_done_i) begin
                  wr_req_q <= 1'b1; // bad data is written anyway
                  err_q    <= err_q | (rd_resp_i != AXI_RESP_OKAY);
                  state_q  <= WRITE;
               end
            end
            WRITE: begin
               if (step) begin
                  err_q   <= err_q | (wr_resp_i != AXI_RESP_OKAY);
                  state_q <= NEXT;
               end
            end
            NEXT: begin
               if (cnt_q == '0) begin
                  done_q  <= 1'b1;
                  state_q <= IDLE;
               end else begin
                  rd_req_q <= 1'b1;
                  state_q  <= READ;
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         src_q <= job_i.src;
         dst_q <= job_i.dst;
         cnt_q <= job_i.cnt;
      end else if (step) begin
         src_q <= src_q + AXI_ADDR_W'(AXI_STRB_W);
         dst_q <= dst_q + AXI_ADDR_W'(AXI_STRB_W);
         cnt_q <= cnt_q - 1'b1;
      end
      if (rd_done_i && (state_q == READ))
         data_q <= rd_data_i;
   end

   assign stat_o    = '{busy: (state_q != IDLE), done: done_q, err: err_q};
   assign rd_req_o  = rd_req_q;
   assign rd_addr_o = src_q;
   assign wr_req_o  = wr_req_q;
   assign wr_addr_o = dst_q;
   assign wr_data_o = data_q;

endmodule

/* design/copy_core.sv */
`timescale 1ns/1ps

module copy_core
   import axi_pkg::*, copy_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n_i,
   input  logic       start_i,
   input  copy_job_t  job_i,
   input  logic       aw_ready_i,
   input  logic       w_ready_i,
   input  logic       b_valid_i,
   input  axi_b_t     b_i,
   input  logic       ar_ready_i,
   input  logic       r_valid_i,
   input  axi_r_t     r_i,
   output copy_stat_t stat_o,
   output logic       aw_valid_o,
   output axi_ax_t    aw_o,
   output logic       w_valid_o,
   output axi_w_t     w_o,
   output logic       b_ready_o,
   output logic       ar_valid_o,
   output axi_ax_t    ar_o,
   output logic       r_ready_o
);

   logic                  rd_req;
   logic [AXI_ADDR_W-1:0] rd_addr;
   logic                  rd_done;
   logic [AXI_DATA_W-1:0] rd_data;
   logic [1:0]            rd_resp;
   logic                  wr_req;
   logic [AXI_ADDR_W-1:0] wr_addr;
   logic [AXI_DATA_W-1:0] wr_data;
   logic                  wr_done;
   logic [1:0]            wr_resp;

   copy_ctrl u_ctrl (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .start_i   (start_i),
      .job_i     (job_i),
      .rd_done_i (rd_done),
      .rd_data_i (rd_data),
      .rd_resp_i (rd_resp),
      .wr_done_i (wr_done),
      .wr_resp_i (wr_resp),
      .stat_o    (stat_o),
      .rd_req_o  (rd_req),
      .rd_addr_o (rd_addr),
      .wr_req_o  (wr_req),
      .wr_addr_o (wr_addr),
      .wr_data_o (wr_data)
   );

   axi_rd_chan u_rd (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .rd_req_i   (rd_req),
      .rd_addr_i  (rd_addr),
      .ar_ready_i (ar_ready_i),
      .r_valid_i  (r_valid_i),
      .r_i        (r_i),
      .ar_valid_o (ar_valid_o),
      .ar_o       (ar_o),
      .r_ready_o  (r_ready_o),
      .rd_done_o  (rd_done),
      .rd_data_o  (rd_data),
      .rd_resp_o  (rd_resp)
   );

   axi_wr_chan u_wr (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .wr_req_i   (wr_req),
      .wr_addr_i  (wr_addr),
      .wr_data_i  (wr_data),
      .aw_ready_i (aw_ready_i),
      .w_ready_i  (w_ready_i),
      .b_valid_i  (b_valid_i),
      .b_i        (b_i),
      .aw_valid_o (aw_valid_o),
      .aw_o       (aw_o),
      .w_valid_o  (w_valid_o),
      .w_o        (w_o),
      .b_ready_o  (b_ready_o),
      .wr_done_o  (wr_done),
      .wr_resp_o  (wr_resp)
   );

endmodule

/* design/sim_top.sv */
`timescale 1ns/1ps

module sim_top
   import axi_pkg::*, copy_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n_i,
   input  logic                  start_i,
   input  copy_job_t             job_i,
   output logic                  busy_o,
   output logic                  done_o,
   output logic                  err_o,

   input  logic                  io_mem_aw_ready_i,
   output logic                  io_mem_aw_valid_o,
   output logic [AXI_ADDR_W-1:0] io_mem_aw_addr_o,
   output logic [AXI_ID_W-1:0]   io_mem_aw_id_o,
   output logic [7:0]            io_mem_aw_len_o,
   output logic [2:0]            io_mem_aw_size_o,
   output logic [1:0]            io_mem_aw_burst_o,
   output logic [2:0]            io_mem_aw_prot_o,
   output logic [3:0]            io_mem_aw_cache_o,
   output logic                  io_mem_aw_lock_o,
   output logic [3:0]            io_mem_aw_qos_o,

   input  logic                  io_mem_w_ready_i,
   output logic                  io_mem_w_valid_o,
   output logic [AXI_DATA_W-1:0] io_mem_w_data_o,
   output logic [AXI_STRB_W-1:0] io_mem_w_strb_o,
   output logic                  io_mem_w_last_o,

   output logic                  io_mem_b_ready_o,
   input  logic                  io_mem_b_valid_i,
   input  logic [1:0]            io_mem_b_resp_i,
   input  logic [AXI_ID_W-1:0]   io_mem_b_id_i,

   input  logic                  io_mem_ar_ready_i,
   output logic                  io_mem_ar_valid_o,
   output logic [AXI_ADDR_W-1:0] io_mem_ar_addr_o,
   output logic [AXI_ID_W-1:0]   io_mem_ar_id_o,
   output logic [7:0]            io_mem_ar_len_o,
   output logic [2:0]            io_mem_ar_size_o,
   output logic [1:0]            io_mem_ar_burst_o,
   output logic [2:0]            io_mem_ar_prot_o,
   output logic [3:0]            io_mem_ar_cache_o,
   output logic                  io_mem_ar_lock_o,
   output logic [3:0]            io_mem_ar_qos_o,

   output logic                  io_mem_r_ready_o,
   input  logic                  io_mem_r_valid_i,
   input  logic [AXI_DATA_W-1:0] io_mem_r_data_i,
   input  logic [1:0]            io_mem_r_resp_i,
   input  logic [AXI_ID_W-1:0]   io_mem_r_id_i,
   input  logic                  io_mem_r_last_i
);

   copy_stat_t stat;
   axi_ax_t    aw;
   axi_ax_t    ar;
   axi_w_t     w;
   axi_b_t     b;
   axi_r_t     r;

   assign busy_o = stat.busy;
   assign done_o = stat.done;
   assign err_o  = stat.err;

   assign io_mem_aw_addr_o  = aw.addr;
   assign io_mem_aw_id_o    = aw.id;
   assign io_mem_aw_len_o   = aw.len;
   assign io_mem_aw_size_o  = aw.size;
   assign io_mem_aw_burst_o = aw.burst;
   assign io_mem_aw_prot_o  = aw.prot;
   assign io_mem_aw_cache_o = aw.cache;
   assign io_mem_aw_lock_o  = aw.lock;
   assign io_mem_aw_qos_o   = aw.qos;

   assign io_mem_w_data_o = w.data;
   assign io_mem_w_strb_o = w.strb;
   assign io_mem_w_last_o = w.last;

   assign b = '{resp: io_mem_b_resp_i, id: io_mem_b_id_i};

   assign io_mem_ar_addr_o  = ar.addr;
   assign io_mem_ar_id_o    = ar.id;
   assign io_mem_ar_len_o   = ar.len;
   assign io_mem_ar_size_o  = ar.size;
   assign io_mem_ar_burst_o = ar.burst;
   assign io_mem_ar_prot_o  = ar.prot;
   assign io_mem_ar_cache_o = ar.cache;
   assign io_mem_ar_lock_o  = ar.lock;
   assign io_mem_ar_qos_o   = ar.qos;

   // r beat back into its struct
   assign r = '{data: io_mem_r_data_i, resp: io_mem_r_resp_i, id: io_mem_r_id_i,
                last: io_mem_r_last_i};

   copy_core u_core (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .start_i    (start_i),
      .job_i      (job_i),
      .aw_ready_i (io_mem_aw_ready_i),
      .w_ready_i  (io_mem_w_ready_i),
      .b_valid_i  (io_mem_b_valid_i),
      .b_i        (b),
      .ar_ready_i (io_mem_ar_ready_i),
      .r_valid_i  (io_mem_r_valid_i),
      .r_i        (r),
      .stat_o     (stat),
      .aw_valid_o (io_mem_aw_valid_o),
      .aw_o       (aw),
      .w_valid_o  (io_mem_w_valid_o),
      .w_o        (w),
      .b_ready_o  (io_mem_b_ready_o),
      .ar_valid_o (io_mem_ar_valid_o),
      .ar_o       (ar),
      .r_ready_o  (io_mem_r_ready_o)
   );

endmodule

/* tb/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
   output logic clk_o
);

   // 10 ns period
   initial begin
      clk_o = 1'b0;
      forever #5 clk_o = ~clk_o;
   end

endmodule

/* tb/tb_axi_mem.sv */
`timescale 1ns/1ps

module tb_axi_mem
   import axi_pkg::*;
(
   input  logic                  clk,
   input  logic                  stall_en_i,
   input  logic [AXI_ADDR_W-1:0] err_lo_i,
   input  logic [AXI_ADDR_W-1:0] err_hi_i,
   input  logic                  aw_valid_i,
   input  logic [AXI_ADDR_W-1:0] aw_addr_i,
   input  logic [AXI_ID_W-1:0]   aw_id_i,
   output logic                  aw_ready_o,
   input  logic                  w_valid_i,
   input  logic [AXI_DATA_W-1:0] w_data_i,
   output logic                  w_ready_o,
   input  logic                  b_ready_i,
   output logic                  b_valid_o,
   output logic [1:0]            b_resp_o,
   output logic [AXI_ID_W-1:0]   b_id_o,
   input  logic                  ar_valid_i,
   input  logic [AXI_ADDR_W-1:0] ar_addr_i,
   input  logic [AXI_ID_W-1:0]   ar_id_i,
   output logic                  ar_ready_o,
   input  logic                  r_ready_i,
   output logic                  r_valid_o,
   output logic [AXI_DATA_W-1:0] r_data_o,
   output logic [1:0]            r_resp_o,
   output logic [AXI_ID_W-1:0]   r_id_o,
   output logic                  r_last_o
);

   localparam logic [1:0] RESP_SLVERR = 2'b10;

   logic [AXI_DATA_W-1:0] mem [logic [AXI_ADDR_W-1:0]];

   // unwritten words come back as a mix of the whole address
   function automatic logic [AXI_DATA_W-1:0] read_word(input logic [AXI_ADDR_W-1:0] addr);
      if (mem.exists(addr))
         return mem[addr];
      return (addr * 64'h9E37_79B9_7F4A_7C15) ^ {addr[31:0], addr[63:32]};
   endfunction

   function automatic logic [1:0] resp_for(input logic [AXI_ADDR_W-1:0] addr);
      if (addr >= err_lo_i && addr <= err_hi_i)
         return RESP_SLVERR;
      return AXI_RESP_OKAY;
   endfunction

   task automatic stall();
      int unsigned n;
      n = stall_en_i ? $urandom_range(3, 0) : 0;
      repeat (n) @(negedge clk);
   endtask

   // read side, one beat at a time
   initial begin
      logic [AXI_ADDR_W-1:0] a;
      ar_ready_o = 1'b0;
      r_valid_o  = 1'b0;
      r_data_o   = '0;
      r_resp_o   = '0;
      r_id_o     = '0;
      r_last_o   = 1'b0;
      forever begin
         @(negedge clk);
         if (ar_valid_i) begin
            stall();
            ar_ready_o = 1'b1;
            a          = ar_addr_i;
            r_id_o     = ar_id_i;
            @(negedge clk);
            ar_ready_o = 1'b0;
            stall();
            r_valid_o = 1'b1;
            r_data_o  = read_word(a);
            r_resp_o  = resp_for(a); // data still valid on error
            r_last_o  = 1'b1;
            while (!r_ready_i)
               @(negedge clk);
            @(negedge clk);
            r_valid_o = 1'b0;
         end
      end
   end

   // write side, AW and W accepted in either order
   initial begin
      logic [AXI_ADDR_W-1:0] a;
      logic [AXI_DATA_W-1:0] d;
      aw_ready_o = 1'b0;
      w_ready_o  = 1'b0;
      b_valid_o  = 1'b0;
      b_resp_o   = '0;
      b_id_o     = '0;
      forever begin
         @(negedge clk);
         if (aw_valid_i && w_valid_i) begin
            fork
               begin
                  stall();
                  aw_ready_o = 1'b1;
                  a          = aw_addr_i;
                  b_id_o     = aw_id_i;
                  @(negedge clk);
                  aw_ready_o = 1'b0;
               end
               begin
                  stall();
                  w_ready_o = 1'b1;
                  d         = w_data_i;
                  @(negedge clk);
                  w_ready_o = 1'b0;
               end
            join
            mem[a] = d; // stored even inside the error range
            stall();
            b_valid_o = 1'b1;
            b_resp_o  = resp_for(a);
            while (!b_ready_i)
               @(negedge clk);
            @(negedge clk);
            b_valid_o = 1'b0;
         end
      end
   end

endmodule

/* tb/tb_top.sv */
`timescale 1ns/1ps

module tb_top
   import axi_pkg::*, copy_pkg::*;
();

   localparam int                    N_RAND   = 20;
   localparam logic [AXI_ADDR_W-1:0] SRC_BASE = 64'h1000_0000;
   localparam logic [AXI_ADDR_W-1:0] DST_BASE = 64'h2000_0000;
   localparam logic [AXI_ADDR_W-1:0] ERR_LO   = 64'h3000_0000;
   localparam logic [AXI_ADDR_W-1:0] ERR_HI   = 64'h3000_00ff;

   logic                  clk;
   logic                  rst_n_i;
   logic                  start_i;
   copy_job_t             job_i;
   logic                  busy_o, done_o, err_o;
   logic                  io_mem_aw_ready_i, io_mem_w_ready_i, io_mem_ar_ready_i;
   logic                  io_mem_aw_valid_o, io_mem_w_valid_o, io_mem_ar_valid_o;
   logic                  io_mem_b_ready_o, io_mem_r_ready_o;
   logic                  io_mem_b_valid_i, io_mem_r_valid_i, io_mem_r_last_i;
   logic [AXI_ADDR_W-1:0] io_mem_aw_addr_o, io_mem_ar_addr_o;
   logic [AXI_ID_W-1:0]   io_mem_aw_id_o, io_mem_ar_id_o, io_mem_b_id_i, io_mem_r_id_i;
   logic [7:0]            io_mem_aw_len_o, io_mem_ar_len_o;
   logic [2:0]            io_mem_aw_size_o, io_mem_ar_size_o;
   logic [1:0]            io_mem_aw_burst_o, io_mem_ar_burst_o;
   logic [2:0]            io_mem_aw_prot_o, io_mem_ar_prot_o;
   logic [3:0]            io_mem_aw_cache_o, io_mem_ar_cache_o;
   logic                  io_mem_aw_lock_o, io_mem_ar_lock_o;
   logic [3:0]            io_mem_aw_qos_o, io_mem_ar_qos_o;
   logic [AXI_DATA_W-1:0] io_mem_w_data_o, io_mem_r_data_i;
   logic [AXI_STRB_W-1:0] io_mem_w_strb_o;
   logic                  io_mem_w_last_o;
   logic [1:0]            io_mem_b_resp_i, io_mem_r_resp_i;

   logic                  stall_en;
   logic                  in_job;
   logic                  exp_err;
   copy_job_t             cur_job;
   copy_stat_t            stat_now;
   axi_ax_t               ar_seen, aw_seen, ar_prev, aw_prev;
   logic                  ar_prev_v, aw_prev_v, w_prev_v;
   logic [AXI_DATA_W-1:0] w_prev;
   logic [AXI_DATA_W-1:0] exp_words[$];
   int unsigned           done_cnt, bus_cnt, wd_cycles;
   time                   t_start, done_time;

   tb_clk_gen u_clk (.clk_o(clk));

   sim_top UUT (.*);

   tb_axi_mem u_mem (
      .clk        (clk),
      .stall_en_i (stall_en),
      .err_lo_i   (ERR_LO),
      .err_hi_i   (ERR_HI),
      .aw_valid_i (io_mem_aw_valid_o),
      .aw_addr_i  (io_mem_aw_addr_o),
      .aw_id_i    (io_mem_aw_id_o),
      .aw_ready_o (io_mem_aw_ready_i),
      .w_valid_i  (io_mem_w_valid_o),
      .w_data_i   (io_mem_w_data_o),
      .w_ready_o  (io_mem_w_ready_i),
      .b_ready_i  (io_mem_b_ready_o),
      .b_valid_o  (io_mem_b_valid_i),
      .b_resp_o   (io_mem_b_resp_i),
      .b_id_o     (io_mem_b_id_i),
      .ar_valid_i (io_mem_ar_valid_o),
      .ar_addr_i  (io_mem_ar_addr_o),
      .ar_id_i    (io_mem_ar_id_o),
      .ar_ready_o (io_mem_ar_ready_i),
      .r_ready_i  (io_mem_r_ready_o),
      .r_valid_o  (io_mem_r_valid_i),
      .r_data_o   (io_mem_r_data_i),
      .r_resp_o   (io_mem_r_resp_i),
      .r_id_o     (io_mem_r_id_i),
      .r_last_o   (io_mem_r_last_i)
   );

   assign stat_now = copy_stat_t'{busy: busy_o, done: done_o, err: err_o};
   assign ar_seen  = axi_ax_t'{addr: io_mem_ar_addr_o, id: io_mem_ar_id_o,
                               len: io_mem_ar_len_o, size: io_mem_ar_size_o,
                               burst: io_mem_ar_burst_o, prot: io_mem_ar_prot_o,
                               cache: io_mem_ar_cache_o, lock: io_mem_ar_lock_o,
                               qos: io_mem_ar_qos_o};
   assign aw_seen  = axi_ax_t'{addr: io_mem_aw_addr_o, id: io_mem_aw_id_o,
                               len: io_mem_aw_len_o, size: io_mem_aw_size_o,
                               burst: io_mem_aw_burst_o, prot: io_mem_aw_prot_o,
                               cache: io_mem_aw_cache_o, lock: io_mem_aw_lock_o,
                               qos: io_mem_aw_qos_o};

   task automatic report_error(input string msg);
      $display("ERR @%0d ns: %s", $time, msg);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic check_word(input logic [AXI_DATA_W-1:0] got,
                             input logic [AXI_DATA_W-1:0] exp, input string what);
      if (got !== exp)
         report_error($sformatf("%s: got %h, expected %h", what, got, exp));
   endtask

   task automatic check_stat(input copy_stat_t got, input copy_stat_t exp, input string what);
      if (got !== exp)
         report_error($sformatf("%s: busy/done/err %b, expected %b", what, got, exp));
   endtask

   task automatic check_ax(input axi_ax_t got, input axi_ax_t exp, input string what);
      if (got !== exp)
         report_error($sformatf("%s: got %h, expected %h", what, got, exp));
   endtask

   // len 0, 8 byte beat, INCR, fixed id
   function automatic axi_ax_t single_beat_ax(input logic [AXI_ADDR_W-1:0] addr);
      axi_ax_t ax;
      ax       = '0;
      ax.addr  = addr;
      ax.id    = AXI_ID_COPY;
      ax.size  = 3'd3;
      ax.burst = 2'b01;
      return ax;
   endfunction

   // dst word i gets src word i as it was before the job; err if any word hits the range
   function automatic logic copy_expect(input copy_job_t job,
                                        input logic [AXI_DATA_W-1:0] src_words[$],
                                        output logic [AXI_DATA_W-1:0] dst_words[$]);
      logic                  err;
      logic [AXI_ADDR_W-1:0] s;
      logic [AXI_ADDR_W-1:0] d;
      err       = 1'b0;
      dst_words = {};
      for (int i = 0; i < int'(job.cnt); i++) begin
         s = job.src + 64'(8 * i);
         d = job.dst + 64'(8 * i);
         dst_words.push_back(src_words[i]);
         if ((s >= ERR_LO && s <= ERR_HI) || (d >= ERR_LO && d <= ERR_HI))
            err = 1'b1;
      end
      return err;
   endfunction

   task automatic run_job(input copy_job_t job, input logic stalls);
      logic [AXI_DATA_W-1:0] src_words[$];
      int unsigned           n0;
      for (int i = 0; i < int'(job.cnt); i++)
         src_words.push_back(u_mem.read_word(job.src + 64'(8 * i)));
      exp_err  = copy_expect(job, src_words, exp_words);
      cur_job  = job;
      stall_en = stalls;
      n0       = done_cnt;
      @(negedge clk);
      start_i = 1'b1;
      job_i   = job;
      @(negedge clk);
      start_i = 1'b0;
      t_start = $time;
      in_job  = 1'b1;
      wait (done_cnt != n0);
   endtask

   // result check at done, busy check in between
   initial begin
      copy_stat_t mid;
      forever begin
         @(negedge clk);
         if (done_o) begin
            if (!in_job)
               report_error("done_o pulsed with no accepted job");
            check_stat(stat_now, copy_stat_t'{busy: 1'b0, done: 1'b1, err: exp_err},
                       "status at done");
            for (int i = 0; i < exp_words.size(); i++)
               check_word(u_mem.read_word(cur_job.dst + 64'(8 * i)), exp_words[i],
                          $sformatf("dst word %0d", i));
            in_job    = 1'b0;
            done_time = $time;
            done_cnt++;
         end else if (in_job) begin
            mid = stat_now;
            if (exp_err)
               mid.err = 1'b0; // err may rise at any word of a failing job
            check_stat(mid, copy_stat_t'{busy: 1'b1, done: 1'b0, err: 1'b0},
                       "status during job");
         end
      end
   end

   // payload rules on the bus
   initial begin
      forever begin
         @(negedge clk);
         if (io_mem_ar_valid_o) begin
            check_ax(ar_seen, single_beat_ax(ar_seen.addr), "AR fields");
            if (ar_prev_v)
               check_ax(ar_seen, ar_prev, "AR payload while waiting");
         end
         if (io_mem_aw_valid_o) begin
            check_ax(aw_seen, single_beat_ax(aw_seen.addr), "AW fields");
            if (aw_prev_v)
               check_ax(aw_seen, aw_prev, "AW payload while waiting");
         end
         if (io_mem_w_valid_o) begin
            check_word(64'({io_mem_w_strb_o, io_mem_w_last_o}), 64'h1ff, "W strobe and last");
            if (w_prev_v)
               check_word(io_mem_w_data_o, w_prev, "W data while waiting");
         end
         if (io_mem_aw_valid_o || io_mem_w_valid_o || io_mem_ar_valid_o ||
             io_mem_b_ready_o || io_mem_r_ready_o)
            bus_cnt++;
         ar_prev_v = io_mem_ar_valid_o;
         aw_prev_v = io_mem_aw_valid_o;
         w_prev_v  = io_mem_w_valid_o;
         ar_prev   = ar_seen;
         aw_prev   = aw_seen;
         w_prev    = io_mem_w_data_o;
      end
   end

   initial begin
      wait (wd_cycles != 0);
      repeat (wd_cycles) @(posedge clk);
      $display("Timeout: the copy jobs did not finish within %0d cycles", wd_cycles);
      $display("Simulation failed");
      $fatal(1);
   end

   initial begin
      copy_job_t             rjobs[N_RAND];
      copy_job_t             jb;
      logic [AXI_DATA_W-1:0] jb_before[$];
      int unsigned           total;
      int unsigned           n_bus;
      int unsigned           n_done;
      rst_n_i   = 1'b0;
      start_i   = 1'b0;
      job_i     = '0;
      stall_en  = 1'b0;
      in_job    = 1'b0;
      exp_err   = 1'b0;
      ar_prev_v = 1'b0;
      aw_prev_v = 1'b0;
      w_prev_v  = 1'b0;
      void'($urandom(59923));
      total = 16 + 8 + 4 + 6 + 6;
      for (int j = 0; j < N_RAND; j++) begin
         rjobs[j].src = SRC_BASE + 64'($urandom_range(4095, 0) * 8);
         rjobs[j].dst = DST_BASE + 64'($urandom_range(4095, 0) * 8);
         rjobs[j].cnt = 16'($urandom_range(32, 1));
         total += rjobs[j].cnt;
      end
      wd_cycles = total * 200 + 1000;

      repeat (10) @(negedge clk);
      rst_n_i = 1'b1;
      repeat (3) begin
         @(negedge clk);
         check_word(64'({io_mem_aw_valid_o, io_mem_w_valid_o, io_mem_ar_valid_o,
                         io_mem_b_ready_o, io_mem_r_ready_o}), '0, "bus idle after reset");
         check_stat(stat_now, '0, "status after reset");
      end

      run_job('{src: SRC_BASE, dst: DST_BASE + 64'hC000, cnt: 16'd16}, 1'b0);
      for (int j = 0; j < N_RAND; j++)
         run_job(rjobs[j], 1'b1);

      // source straddles the error range
      run_job('{src: ERR_LO - 64'd32, dst: DST_BASE + 64'hA000, cnt: 16'd8}, 1'b1);
      run_job('{src: SRC_BASE + 64'h100, dst: DST_BASE + 64'hD000, cnt: 16'd4}, 1'b1);

      n_bus = bus_cnt;
      run_job('{src: SRC_BASE, dst: DST_BASE + 64'hB000, cnt: '0}, 1'b0);
      check_word(64'(done_time - t_start), 64'd10, "zero count done delay in ns");
      check_word(64'(bus_cnt - n_bus), 64'd0, "bus cycles in zero count job");

      // second start lands while the first job is busy
      jb = '{src: SRC_BASE + 64'h4000, dst: DST_BASE + 64'h9000, cnt: 16'd6};
      for (int i = 0; i < 6; i++)
         jb_before.push_back(u_mem.read_word(jb.dst + 64'(8 * i)));
      n_done = done_cnt;
      fork
         run_job('{src: SRC_BASE + 64'h2000, dst: DST_BASE + 64'hE000, cnt: 16'd6}, 1'b1);
         begin
            repeat (4) @(negedge clk);
            start_i = 1'b1;
            job_i   = jb;
            @(negedge clk);
            start_i = 1'b0;
         end
      join
      repeat (40) @(negedge clk);
      check_word(64'(done_cnt - n_done), 64'd1, "done pulses for one accepted start");
      for (int i = 0; i < 6; i++)
         check_word(u_mem.read_word(jb.dst + 64'(8 * i)), jb_before[i],
                    $sformatf("ignored job dst word %0d", i));

      repeat (5) @(negedge clk);
      $display("Simulation passed");
      $finish;
   end

endmodule

/* sim.f */
design/axi_pkg.sv
design/copy_pkg.sv
design/axi_rd_chan.sv
design/axi_wr_chan.sv
design/copy_ctrl.sv
design/copy_core.sv
design/sim_top.sv
tb/tb_clk_gen.sv
tb/tb_axi_mem.sv
tb/tb_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds and runs the copy engine testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -j 0 -f sim.f --top-module tb_top -o tb_top_sim

# the simulation status is judged from the log below
./obj_dir/tb_top_sim 2>&1 | tee sim.log

if grep -q "Simulation failed" sim.log; then
   echo "run_sim: FAIL"
   exit 1
fi
if ! grep -q "Simulation passed" sim.log; then
   echo "run_sim: no result line in sim.log"
   exit 1
fi
echo "run_sim: PASS"
